//--- hdl/tcdm_pkg.sv
// Geometry of the word-interleaved TCDM and the request/response types
// shared by the masters, the interconnect and the banks
package tcdm_pkg;

  // ----------------------------------------
  // Geometry
  // ----------------------------------------
  localparam int unsigned NUM_TILES      = 4;
  // DMA sits on the last master index
  localparam int unsigned NUM_PORTS      = NUM_TILES + 1;
  localparam int unsigned NUM_BANKS      = 4;
  localparam int unsigned BANK_WORDS     = 16;
  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned BE_WIDTH       = 4;
  localparam int unsigned ADDR_WIDTH     = 6;
  // Low address bits pick the bank, high bits the row
  localparam int unsigned BANK_SEL_WIDTH = 2;
  localparam int unsigned ROW_WIDTH      = 4;
  localparam int unsigned PORT_ID_WIDTH  = 3;

  // ----------------------------------------
  // Types
  // ----------------------------------------
  // Master request, word addressed
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  wen;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0]   be;
  } tcdm_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
  } tcdm_resp_t;

  // Access as seen by a single bank
  typedef struct packed {
    logic [ROW_WIDTH-1:0]  row;
    logic                  wen;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0]   be;
  } bank_req_t;

endpackage : tcdm_pkg

//--- hdl/dma_pkg.sv
// DMA copy request, status and backend state definitions
package dma_pkg;
  import tcdm_pkg::*;

  // Word count, up to 64 words
  localparam int unsigned LEN_WIDTH = 7;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] src;
    logic [ADDR_WIDTH-1:0] dst;
    logic [LEN_WIDTH-1:0]  num_words;
  } dma_req_t;

  typedef struct packed {
    logic backend_idle;
    logic trans_complete;
  } dma_meta_t;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_READ,
    DMA_WAIT,
    DMA_WRITE
  } dma_state_e;

endpackage : dma_pkg

//--- hdl/tcdm_bank.sv
`timescale 1ns/100ps
// Single-port TCDM bank with byte-enabled writes
// Read data is registered and valid the cycle after the request
module tcdm_bank
  import tcdm_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  req_i,
  input  bank_req_t             req_data_i,
  output logic [DATA_WIDTH-1:0] rdata_o
);

  logic [DATA_WIDTH-1:0] mem_q [BANK_WORDS];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < BANK_WORDS; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o <= '0;
    end else if (req_i) begin
      if (req_data_i.wen) begin
        // Merge only the enabled bytes
        for (int b = 0; b < BE_WIDTH; b++) begin
          if (req_data_i.be[b]) begin
            mem_q[req_data_i.row][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[req_data_i.row];
      end
    end
  end

endmodule : tcdm_bank

//--- hdl/tcdm_interconnect.sv
`timescale 1ns/100ps
// Local TCDM interconnect: bank decode, round-robin grant per bank and
// routing of each bank's response back to its initiator one cycle later
module tcdm_interconnect
  import tcdm_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  // Masters
  input  logic       [NUM_PORTS-1:0]            req_valid_i,
  input  tcdm_req_t  [NUM_PORTS-1:0]            req_i,
  output logic       [NUM_PORTS-1:0]            req_ready_o,
  output logic       [NUM_PORTS-1:0]            resp_valid_o,
  output tcdm_resp_t [NUM_PORTS-1:0]            resp_o,
  // Banks
  output logic       [NUM_BANKS-1:0]            bank_req_o,
  output bank_req_t  [NUM_BANKS-1:0]            bank_req_data_o,
  input  logic       [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_rdata_i
);

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  logic [NUM_PORTS-1:0][BANK_SEL_WIDTH-1:0] port_bank;
  logic [NUM_PORTS-1:0][ROW_WIDTH-1:0]      port_row;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_decode
    assign port_bank[p] = req_i[p].addr[BANK_SEL_WIDTH-1:0];
    assign port_row[p]  = req_i[p].addr[ADDR_WIDTH-1:BANK_SEL_WIDTH];
  end : gen_decode

  // ----------------------------------------
  // Round-robin arbitration
  // ----------------------------------------
  logic [NUM_BANKS-1:0][PORT_ID_WIDTH-1:0] rr_ptr_q;
  logic [NUM_BANKS-1:0]                    bank_gnt_valid;
  logic [NUM_BANKS-1:0][PORT_ID_WIDTH-1:0] bank_winner;

  // Search starts at the pointer and wraps over all masters
  always_comb begin
    int unsigned idx;
    bank_gnt_valid = '0;
    bank_winner    = '0;
    for (int unsigned b = 0; b < NUM_BANKS; b++) begin
      for (int unsigned off = 0; off < NUM_PORTS; off++) begin
        idx = (rr_ptr_q[b] + off) % NUM_PORTS;
        if (!bank_gnt_valid[b] && req_valid_i[idx] &&
            (port_bank[idx] == b[BANK_SEL_WIDTH-1:0])) begin
          bank_gnt_valid[b] = 1'b1;
          bank_winner[b]    = idx[PORT_ID_WIDTH-1:0];
        end
      end
    end
  end

  always_comb begin
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      req_ready_o[p] = bank_gnt_valid[port_bank[p]] &&
                       (bank_winner[port_bank[p]] == p[PORT_ID_WIDTH-1:0]);
    end
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank_req
    assign bank_req_o[b]            = bank_gnt_valid[b];
    assign bank_req_data_o[b].row   = port_row[bank_winner[b]];
    assign bank_req_data_o[b].wen   = req_i[bank_winner[b]].wen;
    assign bank_req_data_o[b].wdata = req_i[bank_winner[b]].wdata;
    assign bank_req_data_o[b].be    = req_i[bank_winner[b]].be;
  end : gen_bank_req

  // ----------------------------------------
  // Response tracking
  // ----------------------------------------
  logic [NUM_BANKS-1:0]                    pending_q;
  logic [NUM_BANKS-1:0][PORT_ID_WIDTH-1:0] ini_q;
  logic [NUM_BANKS-1:0]                    read_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      rr_ptr_q  <= '0;
    end else begin
      pending_q <= bank_gnt_valid;
      for (int unsigned b = 0; b < NUM_BANKS; b++) begin
        // Pointer moves to the port after the winner
        if (bank_gnt_valid[b]) begin
          rr_ptr_q[b] <= (bank_winner[b] == PORT_ID_WIDTH'(NUM_PORTS - 1)) ?
                         '0 : bank_winner[b] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int unsigned b = 0; b < NUM_BANKS; b++) begin
      ini_q[b]  <= bank_winner[b];
      read_q[b] <= !bank_req_data_o[b].wen;
    end
  end

  // Each port has at most one grant per cycle, so one bank matches
  always_comb begin
    resp_valid_o = '0;
    resp_o       = '0;
    for (int unsigned b = 0; b < NUM_BANKS; b++) begin
      if (pending_q[b]) begin
        resp_valid_o[ini_q[b]] = 1'b1;
        resp_o[ini_q[b]].rdata = read_q[b] ? bank_rdata_i[b] : '0;
      end
    end
  end

endmodule : tcdm_interconnect

//--- hdl/dma_backend.sv
`timescale 1ns/100ps
// Single DMA backend: buffers one copy request and moves it word by word
// through the TCDM as the last interconnect master
module dma_backend
  import tcdm_pkg::*;
  import dma_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  // Copy request and status
  input  dma_req_t   dma_req_i,
  input  logic       dma_req_valid_i,
  output logic       dma_req_ready_o,
  output dma_meta_t  dma_meta_o,
  // TCDM master port
  output logic       tcdm_req_valid_o,
  output tcdm_req_t  tcdm_req_o,
  input  logic       tcdm_req_ready_i,
  input  logic       tcdm_resp_valid_i,
  input  tcdm_resp_t tcdm_resp_i
);

  // ----------------------------------------
  // Request buffer
  // ----------------------------------------
  // Entry stays occupied until the copy has finished
  logic     buf_valid_q;
  dma_req_t buf_q;
  logic     accept;
  logic     zero_len;

  dma_state_e             state_q;
  logic [LEN_WIDTH-1:0]   cnt_q;
  logic [DATA_WIDTH-1:0]  data_q;
  logic                   complete_q;
  logic                   last_write;

  assign dma_req_ready_o = !buf_valid_q;
  assign accept          = dma_req_valid_i && dma_req_ready_o;
  assign zero_len        = (dma_req_i.num_words == '0);

  // ----------------------------------------
  // Copy FSM
  // ----------------------------------------
  assign last_write = (state_q == DMA_WRITE) && tcdm_req_ready_i &&
                      (cnt_q == buf_q.num_words - 1'b1);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buf_valid_q <= 1'b0;
      state_q     <= DMA_IDLE;
      cnt_q       <= '0;
      complete_q  <= 1'b0;
    end else begin
      // Zero-length copies complete straight from the handshake
      complete_q <= (accept && zero_len) || last_write;
      if (accept && !zero_len) begin
        buf_valid_q <= 1'b1;
      end else if (last_write) begin
        buf_valid_q <= 1'b0;
      end
      case (state_q)
        DMA_IDLE: begin
          if (buf_valid_q) begin
            cnt_q   <= '0;
            state_q <= DMA_READ;
          end
        end
        DMA_READ: begin
          if (tcdm_req_ready_i) begin
            state_q <= DMA_WAIT;
          end
        end
        DMA_WAIT: begin
          if (tcdm_resp_valid_i) begin
            state_q <= DMA_WRITE;
          end
        end
        DMA_WRITE: begin
          if (last_write) begin
            state_q <= DMA_IDLE;
          end else if (tcdm_req_ready_i) begin
            cnt_q   <= cnt_q + 1'b1;
            state_q <= DMA_READ;
          end
        end
        default: state_q <= DMA_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      buf_q <= dma_req_i;
    end
    if ((state_q == DMA_WAIT) && tcdm_resp_valid_i) begin
      data_q <= tcdm_resp_i.rdata;
    end
  end

  always_comb begin
    tcdm_req_valid_o = 1'b0;
    tcdm_req_o       = '0;
    if (state_q == DMA_READ) begin
      tcdm_req_valid_o = 1'b1;
      tcdm_req_o.addr  = buf_q.src + cnt_q[ADDR_WIDTH-1:0];
    end else if (state_q == DMA_WRITE) begin
      tcdm_req_valid_o = 1'b1;
      tcdm_req_o.addr  = buf_q.dst + cnt_q[ADDR_WIDTH-1:0];
      tcdm_req_o.wen   = 1'b1;
      tcdm_req_o.wdata = data_q;
      tcdm_req_o.be    = '1;
    end
  end

  assign dma_meta_o.backend_idle   = !buf_valid_q && (state_q == DMA_IDLE);
  assign dma_meta_o.trans_complete = complete_q;

endmodule : dma_backend

//--- hdl/mempool_group.sv
`timescale 1ns/100ps
// Group top level: tiles and the DMA share the banked TCDM through
// one local interconnect, with the DMA on the last master port
module mempool_group
  import tcdm_pkg::*;
  import dma_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // Tile ports
  input  logic       [NUM_TILES-1:0]   tile_req_valid_i,
  input  tcdm_req_t  [NUM_TILES-1:0]   tile_req_i,
  output logic       [NUM_TILES-1:0]   tile_req_ready_o,
  output logic       [NUM_TILES-1:0]   tile_resp_valid_o,
  output tcdm_resp_t [NUM_TILES-1:0]   tile_resp_o,
  // DMA request and status
  input  dma_req_t                     dma_req_i,
  input  logic                         dma_req_valid_i,
  output logic                         dma_req_ready_o,
  output dma_meta_t                    dma_meta_o
);

  // ----------------------------------------
  // Master vectors
  // ----------------------------------------
  logic       [NUM_PORTS-1:0] mst_req_valid;
  tcdm_req_t  [NUM_PORTS-1:0] mst_req;
  logic       [NUM_PORTS-1:0] mst_req_ready;
  logic       [NUM_PORTS-1:0] mst_resp_valid;
  tcdm_resp_t [NUM_PORTS-1:0] mst_resp;

  logic       dma_tcdm_valid;
  tcdm_req_t  dma_tcdm_req;

  assign mst_req_valid     = {dma_tcdm_valid, tile_req_valid_i};
  assign mst_req           = {dma_tcdm_req, tile_req_i};
  assign tile_req_ready_o  = mst_req_ready[NUM_TILES-1:0];
  assign tile_resp_valid_o = mst_resp_valid[NUM_TILES-1:0];
  assign tile_resp_o       = mst_resp[NUM_TILES-1:0];

  dma_backend i_dma_backend (
    .clk_i            (clk_i                    ),
    .arst_n_i         (arst_n_i                 ),
    .dma_req_i        (dma_req_i                ),
    .dma_req_valid_i  (dma_req_valid_i          ),
    .dma_req_ready_o  (dma_req_ready_o          ),
    .dma_meta_o       (dma_meta_o               ),
    .tcdm_req_valid_o (dma_tcdm_valid           ),
    .tcdm_req_o       (dma_tcdm_req             ),
    .tcdm_req_ready_i (mst_req_ready[NUM_PORTS-1] ),
    .tcdm_resp_valid_i(mst_resp_valid[NUM_PORTS-1]),
    .tcdm_resp_i      (mst_resp[NUM_PORTS-1]    )
  );

  // ----------------------------------------
  // Interconnect and banks
  // ----------------------------------------
  logic      [NUM_BANKS-1:0]                 bank_req;
  bank_req_t [NUM_BANKS-1:0]                 bank_req_data;
  logic      [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_rdata;

  tcdm_interconnect i_local_interco (
    .clk_i          (clk_i         ),
    .arst_n_i       (arst_n_i      ),
    .req_valid_i    (mst_req_valid ),
    .req_i          (mst_req       ),
    .req_ready_o    (mst_req_ready ),
    .resp_valid_o   (mst_resp_valid),
    .resp_o         (mst_resp      ),
    .bank_req_o     (bank_req      ),
    .bank_req_data_o(bank_req_data ),
    .bank_rdata_i   (bank_rdata    )
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i     (clk_i           ),
      .arst_n_i  (arst_n_i        ),
      .req_i     (bank_req[b]     ),
      .req_data_i(bank_req_data[b]),
      .rdata_o   (bank_rdata[b]   )
    );
  end : gen_banks

endmodule : mempool_group

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps
// Testbench clock and reset source
// 10 ns clock, reset held low for the first 8 cycles
module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule : tb_clock_gen

//--- verification/mempool_group_properties.sv
`timescale 1ns/100ps
// Concurrent checks on grant/response timing and DMA status
// Bound to the group top level from the testbench
module mempool_group_properties
  import tcdm_pkg::*;
  import dma_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic      [NUM_PORTS-1:0] req_valid_i,
  input  logic      [NUM_PORTS-1:0] req_ready_i,
  input  logic      [NUM_PORTS-1:0] resp_valid_i,
  input  tcdm_req_t [NUM_PORTS-1:0] req_i,
  input  dma_req_t                  dma_req_i,
  input  logic                      dma_req_valid_i,
  input  logic                      dma_req_ready_i,
  input  dma_meta_t                 dma_meta_i
);

  int unsigned          fail_cnt;
  logic [NUM_BANKS-1:0] multi_gnt;

  initial fail_cnt = 0;

  // Flags a bank that granted more than one port
  always_comb begin
    logic [NUM_BANKS-1:0] seen;
    seen      = '0;
    multi_gnt = '0;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      if (req_valid_i[p] && req_ready_i[p]) begin
        if (seen[req_i[p].addr[BANK_SEL_WIDTH-1:0]]) begin
          multi_gnt[req_i[p].addr[BANK_SEL_WIDTH-1:0]] = 1'b1;
        end
        seen[req_i[p].addr[BANK_SEL_WIDTH-1:0]] = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Interconnect
  // ----------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      req_valid_i[p] && req_ready_i[p] |=> resp_valid_i[p])
    else begin
      $error("Port %0d got no response one cycle after its grant", p);
      fail_cnt++;
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      resp_valid_i[p] |-> $past(req_valid_i[p] && req_ready_i[p]))
    else begin
      $error("Port %0d got a response without a grant", p);
      fail_cnt++;
    end
  end : gen_port

  assert property (@(posedge clk_i) disable iff (!arst_n_i) multi_gnt == '0)
  else begin
    $error("A bank granted two ports in one cycle");
    fail_cnt++;
  end

  // ----------------------------------------
  // DMA status
  // ----------------------------------------
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dma_meta_i.trans_complete |-> dma_meta_i.backend_idle)
  else begin
    $error("trans_complete high while the backend is busy");
    fail_cnt++;
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dma_req_valid_i && dma_req_ready_i && (dma_req_i.num_words != '0) |=> !dma_req_ready_i)
  else begin
    $error("DMA request ready stayed high with a full buffer");
    fail_cnt++;
  end

endmodule : mempool_group_properties

//--- verification/tb_mempool_group.sv
`timescale 1ns/100ps
// Group testbench: replays the cases file on the tile and DMA ports
// and checks every response against a word-level model of the TCDM
module tb_mempool_group
  import tcdm_pkg::*;
  import dma_pkg::*;
();

  localparam int unsigned TILE_TIMEOUT  = 64;
  localparam int unsigned DMA_TIMEOUT   = 4000;
  localparam int unsigned RESET_TIMEOUT = 50;

  logic                       clk;
  logic                       arst_n;
  logic       [NUM_TILES-1:0] tile_req_valid;
  tcdm_req_t  [NUM_TILES-1:0] tile_req;
  logic       [NUM_TILES-1:0] tile_req_ready;
  logic       [NUM_TILES-1:0] tile_resp_valid;
  tcdm_resp_t [NUM_TILES-1:0] tile_resp;
  dma_req_t                   dma_req;
  logic                       dma_req_valid;
  logic                       dma_req_ready;
  dma_meta_t                  dma_meta;

  // Reference memory, the pending tile requests and the ones queued behind them
  logic [DATA_WIDTH-1:0] ref_mem [NUM_BANKS*BANK_WORDS];
  logic [NUM_TILES-1:0]  pend;
  tcdm_req_t             pend_req [NUM_TILES];
  tcdm_req_t             next_req [NUM_TILES][$];

  tb_clock_gen i_clock_gen (
    .clk_o   (clk   ),
    .arst_n_o(arst_n)
  );

  mempool_group DUT (
    .clk_i            (clk            ),
    .arst_n_i         (arst_n         ),
    .tile_req_valid_i (tile_req_valid ),
    .tile_req_i       (tile_req       ),
    .tile_req_ready_o (tile_req_ready ),
    .tile_resp_valid_o(tile_resp_valid),
    .tile_resp_o      (tile_resp      ),
    .dma_req_i        (dma_req        ),
    .dma_req_valid_i  (dma_req_valid  ),
    .dma_req_ready_o  (dma_req_ready  ),
    .dma_meta_o       (dma_meta       )
  );

  bind mempool_group mempool_group_properties i_properties (
    .clk_i          (clk_i          ),
    .arst_n_i       (arst_n_i       ),
    .req_valid_i    (mst_req_valid  ),
    .req_ready_i    (mst_req_ready  ),
    .resp_valid_i   (mst_resp_valid ),
    .req_i          (mst_req        ),
    .dma_req_i      (dma_req_i      ),
    .dma_req_valid_i(dma_req_valid_i),
    .dma_req_ready_i(dma_req_ready_o),
    .dma_meta_i     (dma_meta_o     )
  );

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "Stopped at the first error");
  endtask

  always @(negedge clk) begin
    assert (DUT.i_properties.fail_cnt == 0) else begin
      $display("A bound property check failed");
      abort_run();
    end
  end

  function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_w,
                                                        input logic [DATA_WIDTH-1:0] new_w,
                                                        input logic [BE_WIDTH-1:0]   be);
    logic [DATA_WIDTH-1:0] res;
    res = old_w;
    for (int b = 0; b < BE_WIDTH; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ----------------------------------------
  // Tile traffic
  // ----------------------------------------
  // Drives every pending request until granted and checks each response
  task automatic run_tiles(input string name, input bit all_ready);
    logic [NUM_TILES-1:0]  grant;
    logic [NUM_TILES-1:0]  due;
    logic [DATA_WIDTH-1:0] exp_rd [NUM_TILES];
    int unsigned           skipped [NUM_TILES];
    int unsigned           cycles;
    logic                  other;
    due    = '0;
    cycles = 0;
    for (int t = 0; t < NUM_TILES; t++) begin
      skipped[t] = 0;
      exp_rd[t]  = '0;
    end
    @(posedge clk);
    tile_req_valid <= pend;
    for (int t = 0; t < NUM_TILES; t++) begin
      tile_req[t] <= pend_req[t];
    end
    while ((pend != '0) || (due != '0)) begin
      @(negedge clk);
      for (int t = 0; t < NUM_TILES; t++) begin
        assert (tile_resp_valid[t] == due[t]) else begin
          $display("Mismatch in %s: tile %0d resp_valid expected %b actual %b",
                   name, t, due[t], tile_resp_valid[t]);
          abort_run();
        end
        if (due[t]) begin
          assert (tile_resp[t].rdata == exp_rd[t]) else begin
            $display("Mismatch in %s: tile %0d rdata expected %h actual %h",
                     name, t, exp_rd[t], tile_resp[t].rdata);
            abort_run();
          end
        end
      end
      grant = pend & tile_req_ready;
      if (all_ready && (cycles == 0)) begin
        assert (grant == pend) else begin
          $display("Mismatch in %s: ready expected %b actual %b", name, pend, tile_req_ready);
          abort_run();
        end
      end
      // Reads see the memory before this cycle's writes
      for (int t = 0; t < NUM_TILES; t++) begin
        if (grant[t]) begin
          exp_rd[t] = pend_req[t].wen ? '0 : ref_mem[pend_req[t].addr];
        end
      end
      for (int t = 0; t < NUM_TILES; t++) begin
        if (grant[t] && pend_req[t].wen) begin
          ref_mem[pend_req[t].addr] = merge_bytes(ref_mem[pend_req[t].addr],
                                                  pend_req[t].wdata, pend_req[t].be);
        end
      end
      for (int t = 0; t < NUM_TILES; t++) begin
        if (pend[t] && !grant[t]) begin
          other = 1'b0;
          for (int u = 0; u < NUM_TILES; u++) begin
            if (grant[u] && (pend_req[u].addr[BANK_SEL_WIDTH-1:0] ==
                             pend_req[t].addr[BANK_SEL_WIDTH-1:0])) begin
              other = 1'b1;
            end
          end
          if (other) begin
            skipped[t]++;
          end
          assert (skipped[t] < NUM_PORTS) else begin
            $display("Tile %0d in %s was passed over by its bank more than %0d times",
                     t, name, NUM_PORTS - 1);
            abort_run();
          end
        end
      end
      due = grant;
      // Granted tiles move on to their next queued request
      for (int t = 0; t < NUM_TILES; t++) begin
        if (grant[t]) begin
          skipped[t] = 0;
          if (next_req[t].size() > 0) begin
            pend_req[t] = next_req[t].pop_front();
          end else begin
            pend[t] = 1'b0;
          end
        end
      end
      cycles++;
      assert (cycles < TILE_TIMEOUT) else begin
        $display("Timed out waiting for tile grants and responses in %s", name);
        abort_run();
      end
      @(posedge clk);
      tile_req_valid <= pend;
      for (int t = 0; t < NUM_TILES; t++) begin
        tile_req[t] <= pend_req[t];
      end
    end
  endtask

  // Consecutive words, so every tile lands on its own bank
  task automatic access_group(input logic [ADDR_WIDTH-1:0] base, input int unsigned n,
                              input bit wen, input bit all_ready, input string name);
    pend = '0;
    for (int t = 0; t < n; t++) begin
      pend[t]     = 1'b1;
      pend_req[t] = '{addr: ADDR_WIDTH'(base + t), wen: wen, wdata: $urandom(), be: '1};
    end
    run_tiles(name, all_ready);
  endtask

  task automatic check_region(input logic [ADDR_WIDTH-1:0] base, input int unsigned n,
                              input string name);
    for (int i = 0; i < n; i += NUM_TILES) begin
      access_group(ADDR_WIDTH'(base + i), (n - i < NUM_TILES) ? n - i : NUM_TILES,
                   1'b0, 1'b0, name);
    end
  endtask

  // All tiles keep hitting one bank, writes with random byte enables
  // alternating with reads
  task automatic bank_conflict(input logic [BANK_SEL_WIDTH-1:0] bank, input int unsigned rounds,
                               input string name);
    logic [ROW_WIDTH-1:0] row;
    tcdm_req_t            req;
    pend = '0;
    for (int r = 0; r < rounds; r++) begin
      for (int t = 0; t < NUM_TILES; t++) begin
        row = ROW_WIDTH'(t + (r / 2) * NUM_TILES);
        req = '{addr: {row, bank}, wen: (r % 2 == 0), wdata: $urandom(),
                be: BE_WIDTH'($urandom())};
        if (r == 0) begin
          pend[t]     = 1'b1;
          pend_req[t] = req;
        end else begin
          next_req[t].push_back(req);
        end
      end
    end
    run_tiles(name, 1'b0);
  endtask

  // ----------------------------------------
  // DMA
  // ----------------------------------------
  task automatic wait_dma_done(input bit busy, input string name);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk);
    if (busy) begin
      assert (!dma_req_ready && !dma_meta.backend_idle) else begin
        $display("DMA still reports idle after accepting a copy in %s", name);
        abort_run();
      end
    end
    while (!dma_meta.trans_complete) begin
      @(negedge clk);
      cycles++;
      assert (cycles < DMA_TIMEOUT) else begin
        $display("No trans_complete pulse within the timeout in %s", name);
        abort_run();
      end
    end
    assert (dma_meta.backend_idle && dma_req_ready) else begin
      $display("DMA not idle at its completion pulse in %s", name);
      abort_run();
    end
  endtask

  task automatic tile_traffic(input logic [ADDR_WIDTH-1:0] base, input string name);
    for (int r = 0; r < 4; r++) begin
      access_group(base, NUM_TILES, (r % 2 == 0), 1'b0, name);
    end
  endtask

  task automatic dma_copy(input logic [ADDR_WIDTH-1:0] src, input logic [ADDR_WIDTH-1:0] dst,
                          input logic [LEN_WIDTH-1:0] len, input logic [ADDR_WIDTH-1:0] tile_base,
                          input bit with_tiles, input string name);
    int unsigned cycles;
    cycles = 0;
    @(posedge clk);
    dma_req       <= '{src: src, dst: dst, num_words: len};
    dma_req_valid <= 1'b1;
    do begin
      @(negedge clk);
      cycles++;
      assert (cycles < TILE_TIMEOUT) else begin
        $display("DMA request was never accepted in %s", name);
        abort_run();
      end
    end while (!dma_req_ready);
    @(posedge clk);
    dma_req_valid <= 1'b0;
    // Forward word-by-word copy
    for (int i = 0; i < len; i++) begin
      ref_mem[ADDR_WIDTH'(dst + i)] = ref_mem[ADDR_WIDTH'(src + i)];
    end
    if (with_tiles) begin
      fork
        wait_dma_done(len != '0, name);
        tile_traffic(tile_base, name);
      join
    end else begin
      wait_dma_done(len != '0, name);
    end
    check_region(dst, (len == '0) ? 1 : len, name);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int          fd;
    int          n_fields;
    int unsigned case_no;
    int unsigned cycles;
    string       line;
    logic [63:0] op;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] a3;
    void'($urandom(6362));
    tile_req_valid = '0;
    tile_req       = '0;
    dma_req        = '0;
    dma_req_valid  = 1'b0;
    pend           = '0;
    case_no        = 0;
    cycles         = 0;
    for (int i = 0; i < NUM_BANKS * BANK_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    while (!arst_n) begin
      @(negedge clk);
      cycles++;
      assert (cycles < RESET_TIMEOUT) else begin
        $display("Reset was never released");
        abort_run();
      end
    end
    @(negedge clk);
    assert ((tile_resp_valid == '0) && dma_meta.backend_idle && !dma_meta.trans_complete &&
            dma_req_ready) else begin
      $display("Outputs are not at their idle values after reset");
      abort_run();
    end

    fd = $fopen("verification/group_cases.txt", "r");
    assert (fd != 0) else begin
      $display("Cannot open the cases file");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      n_fields = 0;
      if ((line.len() > 0) && (line[0] != "#")) begin
        n_fields = $sscanf(line, "%s %h %h %h %h", op, a0, a1, a2, a3);
      end
      if (n_fields >= 1) begin
        case_no++;
        case (op)
          "wr": begin
            pend                      = '0;
            pend[a0 % NUM_TILES]      = 1'b1;
            pend_req[a0 % NUM_TILES]  = '{addr: ADDR_WIDTH'(a1), wen: 1'b1,
                                          wdata: (n_fields >= 5) ? a3 : $urandom(),
                                          be: BE_WIDTH'(a2)};
            run_tiles($sformatf("write case %0d", case_no), 1'b0);
          end
          "rd": begin
            pend                     = '0;
            pend[a0 % NUM_TILES]     = 1'b1;
            pend_req[a0 % NUM_TILES] = '{addr: ADDR_WIDTH'(a1), wen: 1'b0, wdata: '0, be: '0};
            run_tiles($sformatf("read case %0d", case_no), 1'b0);
          end
          "burst": begin
            access_group(ADDR_WIDTH'(a0), NUM_TILES, 1'b1, 1'b1,
                         $sformatf("burst case %0d", case_no));
            access_group(ADDR_WIDTH'(a0), NUM_TILES, 1'b0, 1'b1,
                         $sformatf("burst case %0d", case_no));
          end
          "conflict": begin
            bank_conflict(BANK_SEL_WIDTH'(a0), a1, $sformatf("conflict case %0d", case_no));
          end
          "dma": begin
            dma_copy(ADDR_WIDTH'(a0), ADDR_WIDTH'(a1), LEN_WIDTH'(a2), '0, 1'b0,
                     $sformatf("dma case %0d", case_no));
          end
          "dmabg": begin
            dma_copy(ADDR_WIDTH'(a0), ADDR_WIDTH'(a1), LEN_WIDTH'(a2), ADDR_WIDTH'(a3), 1'b1,
                     $sformatf("dma with tiles case %0d", case_no));
          end
          default: begin
            $display("Unknown operation in cases file record %0d", case_no);
            abort_run();
          end
        endcase
      end
    end
    $fclose(fd);

    repeat (2) @(posedge clk);
    if (DUT.i_properties.fail_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("Bound property checks reported %0d failures", DUT.i_properties.fail_cnt);
      abort_run();
    end
  end

endmodule : tb_mempool_group

//--- verification/group_cases.txt
# op tile addr be [data] | burst base | conflict bank rounds | dma src dst len
# dmabg src dst len tile_base; all fields hex, a wr without data uses random data
wr 0 05 f 12345678
wr 1 05 3
rd 2 05
wr 3 0a 6 a5a55a5a
rd 0 0a
wr 2 11 9
rd 1 11
wr 0 11 2
rd 3 11
rd 3 3f
burst 10
burst 21
burst 00
conflict 1 6
conflict 2 4
conflict 0 2
dma 00 20 4
rd 0 20
dma 10 30 8
dma 04 28 0
rd 1 28
wr 1 38 f
dmabg 20 38 6 04
rd 2 3a
burst 08

//--- tb.f
hdl/tcdm_pkg.sv
hdl/dma_pkg.sv
hdl/tcdm_bank.sv
hdl/tcdm_interconnect.sv
hdl/dma_backend.sv
hdl/mempool_group.sv
verification/tb_clock_gen.sv
verification/mempool_group_properties.sv
verification/tb_mempool_group.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the group testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_mempool_group -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "PASS: all tests" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
